//--- axil_sram_bridge.f
hw/axil_sram_pkg.sv
hw/sync_fifo.sv
hw/sram_cmd_arbiter.sv
hw/write_resp_counter.sv
hw/axil_sram_bridge.sv
tests/sram_model.sv
tests/tb_axil_sram_bridge.sv

//--- run_sim.sh
#!/bin/sh
# Build the AXI-Lite SRAM bridge testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axil_sram_bridge -f axil_sram_bridge.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_axil_sram_bridge)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q '^TESTS PASSED$'; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

//--- tests/tb_axil_sram_bridge.sv
module tb_axil_sram_bridge;

  localparam int NUM_WORDS = 1 << axil_sram_pkg::SRAM_ADDR_WIDTH;
  // about 150 transfers of a few tens of cycles each, with wide margin for stalls
  localparam int TIMEOUT_CYCLES = 20000;

  typedef struct packed {
    axil_sram_pkg::sram_addr_t addr;
    axil_sram_pkg::data_t      data;
    axil_sram_pkg::strb_t      strb;
  } wr_rec_t;

  logic clk;
  logic rst_n;
  axil_sram_pkg::axil_addr_t i_awaddr;
  logic i_awvalid;
  logic o_awready;
  axil_sram_pkg::data_t i_wdata;
  axil_sram_pkg::strb_t i_wstrb;
  logic i_wvalid;
  logic o_wready;
  axil_sram_pkg::resp_t o_bresp;
  logic o_bvalid;
  logic i_bready;
  axil_sram_pkg::axil_addr_t i_araddr;
  logic i_arvalid;
  logic o_arready;
  axil_sram_pkg::data_t o_rdata;
  axil_sram_pkg::resp_t o_rresp;
  logic o_rvalid;
  logic i_rready;
  logic sram_cmd_valid;
  logic sram_cmd_ready;
  axil_sram_pkg::sram_addr_t sram_cmd_addr;
  logic sram_cmd_wr_en;
  axil_sram_pkg::data_t sram_cmd_wr_data;
  axil_sram_pkg::strb_t sram_cmd_wr_strb;
  logic sram_rd_valid;
  logic sram_rd_ready;
  axil_sram_pkg::data_t sram_rd_data;

  // shadow holds what the SRAM should contain once every write is answered
  axil_sram_pkg::data_t shadow[NUM_WORDS];
  wr_rec_t pend_wr[$];
  wr_rec_t wr_cmd_q[$];
  axil_sram_pkg::sram_addr_t rd_cmd_q[$];
  axil_sram_pkg::data_t exp_rd[$];
  axil_sram_pkg::axil_addr_t written[$];
  string test_name = "setup";
  int cycles = 0;

  axil_sram_bridge dut (
    .clk(clk), .rst_n(rst_n),
    .i_awaddr(i_awaddr), .i_awvalid(i_awvalid), .o_awready(o_awready),
    .i_wdata(i_wdata), .i_wstrb(i_wstrb), .i_wvalid(i_wvalid), .o_wready(o_wready),
    .o_bresp(o_bresp), .o_bvalid(o_bvalid), .i_bready(i_bready),
    .i_araddr(i_araddr), .i_arvalid(i_arvalid), .o_arready(o_arready),
    .o_rdata(o_rdata), .o_rresp(o_rresp), .o_rvalid(o_rvalid), .i_rready(i_rready),
    .o_sram_cmd_valid(sram_cmd_valid), .i_sram_cmd_ready(sram_cmd_ready),
    .o_sram_cmd_addr(sram_cmd_addr), .o_sram_cmd_wr_en(sram_cmd_wr_en),
    .o_sram_cmd_wr_data(sram_cmd_wr_data), .o_sram_cmd_wr_strb(sram_cmd_wr_strb),
    .i_sram_resp_rd_valid(sram_rd_valid), .o_sram_resp_rd_ready(sram_rd_ready),
    .i_sram_resp_rd_data(sram_rd_data)
  );

  sram_model u_sram (
    .clk(clk), .rst_n(rst_n),
    .i_cmd_valid(sram_cmd_valid), .o_cmd_ready(sram_cmd_ready),
    .i_cmd_addr(sram_cmd_addr), .i_cmd_wr_en(sram_cmd_wr_en),
    .i_cmd_wr_data(sram_cmd_wr_data), .i_cmd_wr_strb(sram_cmd_wr_strb),
    .o_rd_valid(sram_rd_valid), .i_rd_ready(sram_rd_ready), .o_rd_data(sram_rd_data)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $fatal(1);
    end
  end

  task automatic report_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("ERR %s: %s expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic report_text(input string msg);
    $display("%s: %s", test_name, msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  function automatic axil_sram_pkg::data_t fill_word(input axil_sram_pkg::sram_addr_t addr);
    return {addr, 1'b1, ~addr, 1'b0} ^ 16'h5a3c;
  endfunction

  // byte lanes with a strobe take the new data, the rest keep the old word
  function automatic axil_sram_pkg::data_t merge_word(input axil_sram_pkg::data_t old_word,
                                                      input axil_sram_pkg::data_t new_data,
                                                      input axil_sram_pkg::strb_t strb);
    axil_sram_pkg::data_t merged;
    merged = old_word;
    for (int b = 0; b < axil_sram_pkg::STRB_WIDTH; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_data[8*b +: 8];
      end
    end
    return merged;
  endfunction

  function automatic void note_write(input axil_sram_pkg::axil_addr_t addr,
                                     input axil_sram_pkg::data_t data,
                                     input axil_sram_pkg::strb_t strb);
    wr_rec_t w;
    w.addr = axil_sram_pkg::sram_addr_t'(addr >> 1);
    w.data = data;
    w.strb = strb;
    pend_wr.push_back(w);
    wr_cmd_q.push_back(w);
    written.push_back(addr);
  endfunction

  function automatic void note_read(input axil_sram_pkg::axil_addr_t addr);
    axil_sram_pkg::sram_addr_t word;
    word = axil_sram_pkg::sram_addr_t'(addr >> 1);
    rd_cmd_q.push_back(word);
    exp_rd.push_back(shadow[word]);
  endfunction

  function automatic axil_sram_pkg::axil_addr_t pick_written();
    return written[$urandom_range(written.size() - 1)];
  endfunction

  // a W beat stuck for 8 cycles while bready is low releases bready
  task automatic write_beat(input axil_sram_pkg::axil_addr_t addr,
                            input axil_sram_pkg::data_t data,
                            input axil_sram_pkg::strb_t strb);
    logic aw_hs;
    logic w_hs;
    int   held;
    held      = 0;
    i_awaddr  = addr;
    i_awvalid = 1'b1;
    i_wdata   = data;
    i_wstrb   = strb;
    i_wvalid  = 1'b1;
    while (i_awvalid || i_wvalid) begin
      @(negedge clk);
      aw_hs = i_awvalid && o_awready;
      w_hs  = i_wvalid && o_wready;
      @(posedge clk);
      #2;
      if (aw_hs) begin
        i_awvalid = 1'b0;
      end
      if (w_hs) begin
        i_wvalid = 1'b0;
      end
      held = w_hs ? 0 : held + 1;
      if (held == 8 && !i_bready) begin
        i_bready = 1'b1;
      end
    end
    note_write(addr, data, strb);
  endtask

  // an AR stuck for 8 cycles while rready is low releases rready
  task automatic read_req(input axil_sram_pkg::axil_addr_t addr);
    logic hs;
    int   held;
    held      = 0;
    i_araddr  = addr;
    i_arvalid = 1'b1;
    while (i_arvalid) begin
      @(negedge clk);
      hs = o_arready;
      @(posedge clk);
      #2;
      if (hs) begin
        i_arvalid = 1'b0;
      end
      held = hs ? 0 : held + 1;
      if (held == 8 && !i_rready) begin
        assert (o_rvalid) else report_text("no read data came back while rready was low");
        i_rready = 1'b1;
      end
    end
    note_read(addr);
  endtask

  task automatic wait_idle();
    while (pend_wr.size() != 0 || wr_cmd_q.size() != 0 || rd_cmd_q.size() != 0 ||
           exp_rd.size() != 0) begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
  endtask

  // SRAM commands must follow request order within reads and within writes
  always @(negedge clk) begin : watch_cmd
    wr_rec_t w;
    axil_sram_pkg::sram_addr_t a;
    if (rst_n && sram_cmd_valid && sram_cmd_ready) begin
      if (sram_cmd_wr_en) begin
        assert (wr_cmd_q.size() != 0) else report_text("SRAM write with no write pending");
        w = wr_cmd_q.pop_front();
        assert (sram_cmd_addr == w.addr) else report_value("write addr", w.addr, sram_cmd_addr);
        assert (sram_cmd_wr_data == w.data)
          else report_value("write data", w.data, sram_cmd_wr_data);
        assert (sram_cmd_wr_strb == w.strb)
          else report_value("write strb", w.strb, sram_cmd_wr_strb);
      end else begin
        assert (rd_cmd_q.size() != 0) else report_text("SRAM read with no read pending");
        a = rd_cmd_q.pop_front();
        assert (sram_cmd_addr == a) else report_value("read addr", a, sram_cmd_addr);
      end
    end
  end

  always @(negedge clk) begin : watch_b
    wr_rec_t w;
    if (rst_n && o_bvalid && i_bready) begin
      assert (o_bresp == axil_sram_pkg::RESP_OKAY) else report_value("bresp", 0, o_bresp);
      assert (pend_wr.size() != 0) else report_text("b response with no write outstanding");
      w = pend_wr.pop_front();
      shadow[w.addr] = merge_word(shadow[w.addr], w.data, w.strb);
    end
  end

  always @(negedge clk) begin : compare_r
    axil_sram_pkg::data_t exp;
    if (rst_n && o_rvalid && i_rready) begin
      assert (exp_rd.size() != 0) else report_text("read data with no read outstanding");
      exp = exp_rd.pop_front();
      assert (o_rdata == exp) else report_value("rdata", 32'(exp), 32'(o_rdata));
      assert (o_rresp == axil_sram_pkg::RESP_OKAY) else report_value("rresp", 0, o_rresp);
    end
  end

  initial begin : main
    axil_sram_pkg::axil_addr_t a;
    axil_sram_pkg::axil_addr_t phase_addr[$];
    int n;
    void'($urandom(59));
    clk       = 1'b0;
    rst_n     = 1'b0;
    i_awaddr  = '0;
    i_awvalid = 1'b0;
    i_wdata   = '0;
    i_wstrb   = '0;
    i_wvalid  = 1'b0;
    i_bready  = 1'b1;
    i_araddr  = '0;
    i_arvalid = 1'b0;
    i_rready  = 1'b1;
    for (int i = 0; i < NUM_WORDS; i++) begin
      shadow[i]     = fill_word(axil_sram_pkg::sram_addr_t'(i));
      u_sram.mem[i] = shadow[i];
    end
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;

    test_name = "reset";
    @(negedge clk);
    assert (!o_bvalid && !o_rvalid && !sram_cmd_valid)
      else report_text("a valid output is high after reset");
    assert (o_awready && o_wready && o_arready) else report_text("a ready is low after reset");
    @(posedge clk);
    #2;

    // reading through the other byte lane address must hit the same word
    test_name = "full_write";
    for (int k = 0; k < 16; k++) begin
      write_beat(axil_sram_pkg::axil_addr_t'($urandom), axil_sram_pkg::data_t'($urandom), 2'b11);
    end
    wait_idle();
    for (int k = 0; k < written.size(); k++) begin
      read_req(written[k] ^ 8'h01);
    end
    wait_idle();

    test_name = "partial_strobe";
    for (int k = 0; k < 12; k++) begin
      a = pick_written();
      write_beat(a, axil_sram_pkg::data_t'($urandom), ($urandom_range(1) != 0) ? 2'b01 : 2'b10);
      phase_addr.push_back(a);
    end
    wait_idle();
    foreach (phase_addr[k]) begin
      read_req(phase_addr[k]);
    end
    wait_idle();

    test_name = "back_to_back_reads";
    repeat (24) read_req(pick_written());
    wait_idle();
    @(negedge clk);
    assert (!o_rvalid) else report_text("read data remained after every read was answered");
    @(posedge clk);
    #2;

    test_name = "read_backpressure";
    i_rready = 1'b0;
    n = 0;
    while (!i_rready) begin
      read_req(pick_written());
      n++;
      assert (n < 32) else report_text("arready never fell while rready was low");
    end
    wait_idle();

    test_name = "write_backpressure";
    phase_addr.delete();
    i_bready = 1'b0;
    n = 0;
    while (!i_bready) begin
      a = axil_sram_pkg::axil_addr_t'($urandom);
      write_beat(a, axil_sram_pkg::data_t'($urandom), axil_sram_pkg::strb_t'($urandom));
      phase_addr.push_back(a);
      n++;
      assert (n < 16) else report_text("wready never fell while bready was low");
    end
    wait_idle();
    @(negedge clk);
    assert (!o_bvalid) else report_text("bvalid stayed high after every write was answered");
    @(posedge clk);
    #2;
    foreach (phase_addr[k]) begin
      read_req(phase_addr[k]);
    end
    wait_idle();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- tests/sram_model.sv
module sram_model (
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic                      i_cmd_valid,
  output logic                      o_cmd_ready,
  input  axil_sram_pkg::sram_addr_t i_cmd_addr,
  input  logic                      i_cmd_wr_en,
  input  axil_sram_pkg::data_t      i_cmd_wr_data,
  input  axil_sram_pkg::strb_t      i_cmd_wr_strb,

  output logic                      o_rd_valid,
  input  logic                      i_rd_ready,
  output axil_sram_pkg::data_t      o_rd_data
);

  // contents are preloaded by the testbench
  axil_sram_pkg::data_t mem[1 << axil_sram_pkg::SRAM_ADDR_WIDTH];

  initial begin : run
    logic                 in_reset;
    logic                 rd_pend;
    axil_sram_pkg::data_t rd_word;
    o_cmd_ready = 1'b0;
    o_rd_valid  = 1'b0;
    o_rd_data   = '0;
    rd_pend     = 1'b0;
    rd_word     = '0;
    forever begin
      // handshakes are decided mid cycle, where both sides are settled
      @(negedge clk);
      in_reset = !rst_n;
      if (in_reset) begin
        rd_pend = 1'b0;
      end else begin
        if (o_rd_valid && i_rd_ready) begin
          rd_pend = 1'b0;
        end
        if (i_cmd_valid && o_cmd_ready) begin
          if (i_cmd_wr_en) begin
            for (int b = 0; b < axil_sram_pkg::STRB_WIDTH; b++) begin
              if (i_cmd_wr_strb[b]) begin
                mem[i_cmd_addr][8*b +: 8] = i_cmd_wr_data[8*b +: 8];
              end
            end
          end else begin
            rd_pend = 1'b1;
            rd_word = mem[i_cmd_addr];
          end
        end
      end
      @(posedge clk);
      #2;
      o_rd_valid = rd_pend;
      o_rd_data  = rd_word;
      // stalls about one cycle in four, and always while read data waits
      o_cmd_ready = !in_reset && !rd_pend && ($urandom_range(3) != 0);
    end
  end

endmodule

//--- hw/axil_sram_bridge.sv
module axil_sram_bridge (
  input  logic clk,
  input  logic rst_n,

  // AXI-Lite subordinate
  input  axil_sram_pkg::axil_addr_t i_awaddr,
  input  logic                      i_awvalid,
  output logic                      o_awready,
  input  axil_sram_pkg::data_t      i_wdata,
  input  axil_sram_pkg::strb_t      i_wstrb,
  input  logic                      i_wvalid,
  output logic                      o_wready,
  output axil_sram_pkg::resp_t      o_bresp,
  output logic                      o_bvalid,
  input  logic                      i_bready,
  input  axil_sram_pkg::axil_addr_t i_araddr,
  input  logic                      i_arvalid,
  output logic                      o_arready,
  output axil_sram_pkg::data_t      o_rdata,
  output axil_sram_pkg::resp_t      o_rresp,
  output logic                      o_rvalid,
  input  logic                      i_rready,

  // SRAM
  output logic                      o_sram_cmd_valid,
  input  logic                      i_sram_cmd_ready,
  output axil_sram_pkg::sram_addr_t o_sram_cmd_addr,
  output logic                      o_sram_cmd_wr_en,
  output axil_sram_pkg::data_t      o_sram_cmd_wr_data,
  output axil_sram_pkg::strb_t      o_sram_cmd_wr_strb,
  input  logic                      i_sram_resp_rd_valid,
  output logic                      o_sram_resp_rd_ready,
  input  axil_sram_pkg::data_t      i_sram_resp_rd_data
);

  logic                      ar_half_full;
  logic                      ar_empty;
  axil_sram_pkg::sram_addr_t ar_head;
  logic                      ar_pop;

  logic                      aw_half_full;
  logic                      aw_empty;
  axil_sram_pkg::sram_addr_t aw_head;

  axil_sram_pkg::w_beat_t    w_beat_in;
  logic                      w_half_full;
  logic                      w_empty;
  axil_sram_pkg::w_beat_t    w_head;

  logic                      r_half_full;
  logic                      r_empty;

  logic                      wr_pop;
  logic                      wr_issued;
  logic                      wr_credit;

  // reads need space for their data in the R FIFO before they are accepted
  assign o_arready = !ar_half_full && !r_half_full;
  assign o_awready = !aw_half_full;
  // hold off new write data while a b response is stuck
  assign o_wready = !w_half_full && !(o_bvalid && !i_bready);
  assign o_sram_resp_rd_ready = !r_half_full;

  assign w_beat_in = '{data: i_wdata, strb: i_wstrb};

  // the dropped address bit only selects the byte lane
  sync_fifo #(.T(axil_sram_pkg::sram_addr_t)) u_ar_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_w_inc      (i_arvalid && o_arready),
    .i_w_data     (i_araddr[axil_sram_pkg::AXIL_ADDR_WIDTH-1:axil_sram_pkg::LSB]),
    .o_w_half_full(ar_half_full),
    .i_r_inc      (ar_pop),
    .o_r_empty    (ar_empty),
    .o_r_data     (ar_head)
  );

  sync_fifo #(.T(axil_sram_pkg::sram_addr_t)) u_aw_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_w_inc      (i_awvalid && o_awready),
    .i_w_data     (i_awaddr[axil_sram_pkg::AXIL_ADDR_WIDTH-1:axil_sram_pkg::LSB]),
    .o_w_half_full(aw_half_full),
    .i_r_inc      (wr_pop),
    .o_r_empty    (aw_empty),
    .o_r_data     (aw_head)
  );

  sync_fifo #(.T(axil_sram_pkg::w_beat_t)) u_w_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_w_inc      (i_wvalid && o_wready),
    .i_w_data     (w_beat_in),
    .o_w_half_full(w_half_full),
    .i_r_inc      (wr_pop),
    .o_r_empty    (w_empty),
    .o_r_data     (w_head)
  );

  // read data comes back in command order, so the R FIFO keeps AXI order
  sync_fifo #(.T(axil_sram_pkg::data_t)) u_r_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_w_inc      (i_sram_resp_rd_valid && o_sram_resp_rd_ready),
    .i_w_data     (i_sram_resp_rd_data),
    .o_w_half_full(r_half_full),
    .i_r_inc      (o_rvalid && i_rready),
    .o_r_empty    (r_empty),
    .o_r_data     (o_rdata)
  );

  assign o_rvalid = !r_empty;
  assign o_rresp = axil_sram_pkg::RESP_OKAY;
  assign o_bresp = axil_sram_pkg::RESP_OKAY;

  sram_cmd_arbiter u_arbiter (
    .clk               (clk),
    .rst_n             (rst_n),
    .i_ar_empty        (ar_empty),
    .i_ar_addr         (ar_head),
    .i_rd_room         (!r_half_full),
    .o_ar_pop          (ar_pop),
    .i_aw_empty        (aw_empty),
    .i_aw_addr         (aw_head),
    .i_w_empty         (w_empty),
    .i_w_beat          (w_head),
    .i_wr_credit       (wr_credit),
    .o_wr_pop          (wr_pop),
    .o_wr_issued       (wr_issued),
    .o_sram_cmd_valid  (o_sram_cmd_valid),
    .i_sram_cmd_ready  (i_sram_cmd_ready),
    .o_sram_cmd_addr   (o_sram_cmd_addr),
    .o_sram_cmd_wr_en  (o_sram_cmd_wr_en),
    .o_sram_cmd_wr_data(o_sram_cmd_wr_data),
    .o_sram_cmd_wr_strb(o_sram_cmd_wr_strb)
  );

  write_resp_counter u_bcnt (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_wr_issued(wr_issued),
    .i_bready   (i_bready),
    .o_bvalid   (o_bvalid),
    .o_wr_credit(wr_credit)
  );

endmodule

//--- hw/write_resp_counter.sv
module write_resp_counter (
  input  logic clk,
  input  logic rst_n,

  input  logic i_wr_issued,
  input  logic i_bready,
  output logic o_bvalid,
  output logic o_wr_credit
);

  // writes taken by the SRAM but not yet acknowledged on the b channel
  logic [axil_sram_pkg::FIFO_ADDR_WIDTH-1:0] count;
  logic [axil_sram_pkg::FIFO_ADDR_WIDTH-1:0] count_next;
  logic                                      b_hs;

  assign b_hs = o_bvalid && i_bready;

  always_comb begin
    count_next = count;
    if (i_wr_issued && !b_hs) begin
      count_next = count + 1'b1;
    end else if (b_hs && !i_wr_issued) begin
      count_next = count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count    <= '0;
      o_bvalid <= 1'b0;
    end else begin
      count    <= count_next;
      o_bvalid <= (count_next != '0);
    end
  end

  // a write already sitting in the command register can still issue after
  // the credit drops, so the count may reach one past the limit
  assign o_wr_credit = (count < axil_sram_pkg::WR_CREDIT_LIMIT);

  // the credit limit keeps the counter inside its range in both directions
  a_no_wrap :
  assert property (@(posedge clk) disable iff (!rst_n)
    !((i_wr_issued && !b_hs && (count == '1)) ||
      (b_hs && !i_wr_issued && (count == '0))));

endmodule

//--- hw/sram_cmd_arbiter.sv
module sram_cmd_arbiter (
  input  logic clk,
  input  logic rst_n,

  // read request side
  input  logic                      i_ar_empty,
  input  axil_sram_pkg::sram_addr_t i_ar_addr,
  input  logic                      i_rd_room,
  output logic                      o_ar_pop,

  // write request side
  input  logic                      i_aw_empty,
  input  axil_sram_pkg::sram_addr_t i_aw_addr,
  input  logic                      i_w_empty,
  input  axil_sram_pkg::w_beat_t    i_w_beat,
  input  logic                      i_wr_credit,
  output logic                      o_wr_pop,
  output logic                      o_wr_issued,

  // SRAM command port
  output logic                      o_sram_cmd_valid,
  input  logic                      i_sram_cmd_ready,
  output axil_sram_pkg::sram_addr_t o_sram_cmd_addr,
  output logic                      o_sram_cmd_wr_en,
  output axil_sram_pkg::data_t      o_sram_cmd_wr_data,
  output axil_sram_pkg::strb_t      o_sram_cmd_wr_strb
);

  logic can_load;
  logic rd_ok;
  logic wr_ok;
  logic rd_start;
  logic wr_start;

  // set after a write so that the next contested slot goes to a read
  logic pri_rd;

  // the command register is free if empty or if it empties this cycle
  assign can_load = !o_sram_cmd_valid || i_sram_cmd_ready;

  assign rd_ok = !i_ar_empty && i_rd_room;
  assign wr_ok = !i_aw_empty && !i_w_empty && i_wr_credit;

  // each side starts when it is eligible and either holds priority or is uncontested
  assign rd_start = can_load && rd_ok && (pri_rd || !wr_ok);
  assign wr_start = can_load && wr_ok && (!pri_rd || !rd_ok);

  assign o_ar_pop = rd_start;
  assign o_wr_pop = wr_start;

  // counted by the response logic once the SRAM has taken the write
  assign o_wr_issued = o_sram_cmd_valid && i_sram_cmd_ready && o_sram_cmd_wr_en;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_sram_cmd_valid <= 1'b0;
      pri_rd           <= 1'b0;
    end else begin
      if (rd_start || wr_start) begin
        o_sram_cmd_valid <= 1'b1;
      end else if (can_load) begin
        o_sram_cmd_valid <= 1'b0;
      end

      if (rd_start) begin
        pri_rd <= 1'b0;
      end else if (wr_start) begin
        pri_rd <= 1'b1;
      end
    end
  end

  // command fields only matter while valid is high
  always_ff @(posedge clk) begin
    if (rd_start) begin
      o_sram_cmd_addr  <= i_ar_addr;
      o_sram_cmd_wr_en <= 1'b0;
    end else if (wr_start) begin
      o_sram_cmd_addr    <= i_aw_addr;
      o_sram_cmd_wr_en   <= 1'b1;
      o_sram_cmd_wr_data <= i_w_beat.data;
      o_sram_cmd_wr_strb <= i_w_beat.strb;
    end
  end

  // a command the SRAM has not taken yet must not change under it
  a_cmd_stable :
  assert property (@(posedge clk) disable iff (!rst_n)
    (o_sram_cmd_valid && !i_sram_cmd_ready) |=>
      (o_sram_cmd_valid && $stable(o_sram_cmd_addr) && $stable(o_sram_cmd_wr_en) &&
       $stable(o_sram_cmd_wr_data) && $stable(o_sram_cmd_wr_strb)));

  // only one request can own the single SRAM port per slot
  a_one_pop :
  assert property (@(posedge clk) disable iff (!rst_n)
    !(o_ar_pop && o_wr_pop));

endmodule

//--- hw/sync_fifo.sv
module sync_fifo #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst_n,

  input  logic i_w_inc,
  input  T     i_w_data,
  output logic o_w_half_full,

  input  logic i_r_inc,
  output logic o_r_empty,
  output T     o_r_data
);

  // storage is indexed by the low pointer bits, the extra msb separates
  // the full case from the empty case
  T mem[1 << axil_sram_pkg::FIFO_ADDR_WIDTH];

  logic [axil_sram_pkg::FIFO_ADDR_WIDTH:0] w_ptr;
  logic [axil_sram_pkg::FIFO_ADDR_WIDTH:0] r_ptr;
  logic [axil_sram_pkg::FIFO_ADDR_WIDTH:0] count;
  logic                                    full;

  assign count = w_ptr - r_ptr;
  assign full = count[axil_sram_pkg::FIFO_ADDR_WIDTH];

  assign o_r_empty = (w_ptr == r_ptr);
  assign o_w_half_full = (count >= (1 << (axil_sram_pkg::FIFO_ADDR_WIDTH - 1)));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_ptr <= '0;
      r_ptr <= '0;
    end else begin
      if (i_w_inc) begin
        w_ptr <= w_ptr + 1'b1;
      end
      if (i_r_inc) begin
        r_ptr <= r_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_w_inc) begin
      mem[w_ptr[axil_sram_pkg::FIFO_ADDR_WIDTH-1:0]] <= i_w_data;
    end
  end

  // the head is read straight from the array, so a write shows up on the
  // next cycle
  assign o_r_data = mem[r_ptr[axil_sram_pkg::FIFO_ADDR_WIDTH-1:0]];

  // the ready logic upstream relies on half full, so the FIFO must never
  // actually overflow
  a_no_overflow :
  assert property (@(posedge clk) disable iff (!rst_n)
    i_w_inc |-> !full);

  // the consumer may only pop when it has seen the FIFO non-empty
  a_no_underflow :
  assert property (@(posedge clk) disable iff (!rst_n)
    i_r_inc |-> !o_r_empty);

endmodule

//--- hw/axil_sram_pkg.sv
package axil_sram_pkg;

  // AXI-Lite side is byte addressed, the SRAM side is word addressed
  localparam int AXIL_ADDR_WIDTH = 8;
  localparam int DATA_WIDTH = 16;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int LSB = 1;
  localparam int SRAM_ADDR_WIDTH = AXIL_ADDR_WIDTH - LSB;

  // channel FIFOs are 4 deep, half full at two entries
  localparam int FIFO_ADDR_WIDTH = 2;

  // writes stop issuing once this many responses are outstanding
  localparam int WR_CREDIT_LIMIT = 2;

  typedef logic [AXIL_ADDR_WIDTH-1:0] axil_addr_t;
  typedef logic [SRAM_ADDR_WIDTH-1:0] sram_addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [STRB_WIDTH-1:0] strb_t;

  // one entry of the write-data FIFO
  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_beat_t;

  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY = 2'b00;

endpackage
